//--- Bender.yml
package:
  name: accel_subsystem

sources:
  - files:
      - hdl/accel_pkg.sv
      - hdl/sram_buffer.sv
      - hdl/route_config.sv
      - hdl/route_controller.sv
      - hdl/operand_fetch.sv
      - hdl/pe_column.sv
      - hdl/output_router.sv
      - hdl/accel_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/accel_properties.sv
      - bench/accel_tb.sv

//--- bench/accel_properties.sv
// ---------------------------------------------------------------------------
// Concurrent checks on the req/ack handshake and the result valid burst,
// bound into the run controller and the output serializer
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module accel_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_req,
    input logic i_ack,
    input logic i_valid
);

    // Ack only rises while req is held
    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> $past(i_req))
        else $error("ack rose while req was low");

    // Host drops req only once ack is up
    req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_req) |-> i_ack)
        else $error("req dropped before ack rose");

    // Exactly four valid cycles per burst
    valid_burst: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_valid) |-> i_valid [*4] ##1 !i_valid)
        else $error("result valid burst was not four cycles long");

endmodule

bind route_controller accel_properties handshake_props (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(i_route_req), .i_ack(o_route_ack), .i_valid(1'b0)
);

// Handshake inputs tied off, only the burst is watched here
bind output_router accel_properties burst_props (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(1'b1), .i_ack(1'b1), .i_valid(o_result_valid)
);

//--- bench/accel_tb.sv
// ---------------------------------------------------------------------------
// Table driven testbench for the compute subsystem: memory fill, route
// runs over the req/ack handshake, reference model and result checks
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module accel_tb import accel_pkg::*; ();

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] w_start;
        logic [ADDR_WIDTH-1:0] i_start;
        logic [ADDR_WIDTH-1:0] size;
        logic                  late_en;
        logic [ADDR_WIDTH-1:0] late_size;
        logic                  keep_size;
    } run_entry_t;

    logic                         clk;
    logic                         rst_n;
    mem_write_t                   mem_wr;
    cfg_write_t                   cfg_wr;
    logic                         route_req;
    logic                         o_route_ack;
    logic [ACC_WIDTH-1:0]         o_result;
    logic                         o_result_valid;
    logic signed [DATA_WIDTH-1:0] w_model [MEM_DEPTH];
    logic [MEM_DATA_WIDTH-1:0]    i_model [MEM_DEPTH];
    run_entry_t                   runs [9];
    integer                       seed;
    int                           errors;
    int                           checks;
    logic                         timed_out;

    tb_clock_gen clk_gen_inst (.o_clk(clk), .o_rst_n(rst_n));

    accel_top i_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_mem_wr      (mem_wr),
        .i_cfg_wr      (cfg_wr),
        .i_route_req   (route_req),
        .o_route_ack   (o_route_ack),
        .o_result      (o_result),
        .o_result_valid(o_result_valid)
    );

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: gave up waiting for %s after 500 cycles", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic check_value(input string name, input int row,
                               input logic [ACC_WIDTH-1:0] expected,
                               input logic [ACC_WIDTH-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s row %0d: expected 0x%h, actual 0x%h",
                     name, row, expected, actual);
        end
    endtask

    // Wrapping 16 bit sum of lane times weight over the route
    function automatic logic [ACC_WIDTH-1:0] model_row(input logic [ADDR_WIDTH-1:0] w0,
                                                       input logic [ADDR_WIDTH-1:0] i0,
                                                       input logic [ADDR_WIDTH-1:0] size,
                                                       input int row);
        logic signed [ACC_WIDTH-1:0]  sum;
        logic signed [ACC_WIDTH-1:0]  prod;
        logic signed [DATA_WIDTH-1:0] lane;
        logic [ADDR_WIDTH-1:0]        wa;
        logic [ADDR_WIDTH-1:0]        ia;
        sum = '0;
        for (int k = 0; k < size; k++) begin
            wa   = ADDR_WIDTH'(w0 + k);
            ia   = ADDR_WIDTH'(i0 + k);
            lane = i_model[ia][row*DATA_WIDTH +: DATA_WIDTH];
            prod = lane * w_model[wa];
            sum  = sum + prod;
        end
        return sum;
    endfunction

    task automatic fill_memories();
        logic [MEM_DATA_WIDTH-1:0] word;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            word = $random(seed);
            w_model[a] = word[DATA_WIDTH-1:0];
            mem_wr = '{en: 1'b1, sel: SEL_WEIGHT, addr: ADDR_WIDTH'(a), data: word};
            tick();
            word = $random(seed);
            i_model[a] = word;
            mem_wr = '{en: 1'b1, sel: SEL_INPUT, addr: ADDR_WIDTH'(a), data: word};
            tick();
        end
        mem_wr = '0;
    endtask

    task automatic write_cfg(input cfg_field_t field, input logic [ADDR_WIDTH-1:0] value);
        cfg_wr = '{en: 1'b1, field: field, value: value};
        tick();
    endtask

    task automatic do_run(input run_entry_t e);
        logic [ACC_WIDTH-1:0] expected [ROW_COUNT];
        int                   waited;
        for (int r = 0; r < ROW_COUNT; r++) begin
            expected[r] = model_row(e.w_start, e.i_start, e.size, r);
        end
        write_cfg(CFG_W_START, e.w_start);
        write_cfg(CFG_I_START, e.i_start);
        // Route size left as it stands from the previous run
        if (!e.keep_size) begin
            write_cfg(CFG_ROUTE_SIZE, e.size);
        end
        cfg_wr = '0;
        route_req = 1'b1;
        // Route size rewrite that lands while the run is busy
        if (e.late_en) begin
            tick();
            tick();
            write_cfg(CFG_ROUTE_SIZE, e.late_size);
            cfg_wr = '0;
        end
        waited = 0;
        while (!o_result_valid && waited < 500) begin
            check_value("o_route_ack", 0, '0, o_route_ack);
            tick();
            waited++;
        end
        if (!o_result_valid) begin
            report_timeout("the first valid result");
            return;
        end
        for (int r = 0; r < ROW_COUNT; r++) begin
            check_value("o_result_valid", r, 1, o_result_valid);
            check_value("o_result", r, expected[r], o_result);
            check_value("o_route_ack", r, '0, o_route_ack);
            tick();
        end
        check_value("o_result_valid", ROW_COUNT, '0, o_result_valid);
        waited = 0;
        while (!o_route_ack && waited < 500) begin
            tick();
            waited++;
        end
        if (!o_route_ack) begin
            report_timeout("o_route_ack to rise");
            return;
        end
        route_req = 1'b0;
        waited = 0;
        while (o_route_ack && waited < 500) begin
            tick();
            waited++;
        end
        if (o_route_ack) begin
            report_timeout("o_route_ack to fall");
        end
    endtask

    initial begin
        int waited;
        mem_wr    = '0;
        cfg_wr    = '0;
        route_req = 1'b0;
        seed      = 71652;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        // w_start, i_start, size, late write enable, late size, keep size
        runs[0] = '{6'd0,  6'd0,  6'd1,  1'b0, 6'd0,  1'b0};
        runs[1] = '{6'd5,  6'd17, 6'd8,  1'b0, 6'd0,  1'b0};
        runs[2] = '{6'd0,  6'd0,  6'd63, 1'b0, 6'd0,  1'b0};
        runs[3] = '{6'd60, 6'd58, 6'd10, 1'b0, 6'd0,  1'b0};
        runs[4] = '{6'd3,  6'd40, 6'd0,  1'b0, 6'd0,  1'b0};
        runs[5] = '{6'd12, 6'd20, 6'd6,  1'b1, 6'd40, 1'b0};
        // The size written during run 5 was dropped, so 6 still holds
        runs[6] = '{6'd12, 6'd20, 6'd6,  1'b0, 6'd0,  1'b1};
        runs[7] = '{6'd12, 6'd20, 6'd40, 1'b0, 6'd0,  1'b0};
        runs[8] = '{6'd33, 6'd1,  6'd31, 1'b0, 6'd0,  1'b0};
        waited = 0;
        while (!rst_n && waited < 500) begin
            tick();
            waited++;
        end
        if (!rst_n) begin
            report_timeout("reset release");
        end else begin
            // Quiet outputs while req stays low
            for (int c = 0; c < 10; c++) begin
                check_value("o_route_ack", 0, '0, o_route_ack);
                check_value("o_result_valid", 0, '0, o_result_valid);
                tick();
            end
            fill_memories();
            for (int n = 0; n < $size(runs) && !timed_out; n++) begin
                do_run(runs[n]);
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
// ---------------------------------------------------------------------------
// Testbench clock source, 20 ns period, with an active low reset held for
// the first two rising edges
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        #2;
        o_rst_n = 1'b1;
    end

endmodule

//--- hdl/accel_pkg.sv
// ---------------------------------------------------------------------------
// Shared sizes, payload structs, host write records and the run FSM state
// encoding for the convolution compute subsystem
// ---------------------------------------------------------------------------
package accel_pkg;

    localparam int DATA_WIDTH     = 8;
    localparam int ACC_WIDTH      = 16;
    localparam int ROW_COUNT      = 4;
    localparam int ADDR_WIDTH     = 6;
    localparam int MEM_DEPTH      = 2 ** ADDR_WIDTH;
    localparam int MEM_DATA_WIDTH = 32;
    localparam int ROW_IDX_WIDTH  = $clog2(ROW_COUNT);
    localparam int DRAIN_CYCLES   = 2;

    // Memory payloads
    typedef logic signed [DATA_WIDTH-1:0] weight_word_t;

    typedef struct packed {
        logic [ROW_COUNT-1:0][DATA_WIDTH-1:0] lane;
    } ifmap_word_t;

    // Host side writes
    typedef enum logic {SEL_WEIGHT, SEL_INPUT} mem_sel_t;

    typedef struct packed {
        logic                      en;
        mem_sel_t                  sel;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [MEM_DATA_WIDTH-1:0] data;
    } mem_write_t;

    typedef enum logic [1:0] {CFG_W_START, CFG_I_START, CFG_ROUTE_SIZE} cfg_field_t;

    typedef struct packed {
        logic                  en;
        cfg_field_t            field;
        logic [ADDR_WIDTH-1:0] value;
    } cfg_write_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] w_start;
        logic [ADDR_WIDTH-1:0] i_start;
        logic [ADDR_WIDTH-1:0] route_size;
    } route_cfg_t;

    // Datapath
    typedef struct packed {
        logic         valid;
        weight_word_t weight;
        ifmap_word_t  ifmap;
    } operand_t;

    typedef struct packed {
        logic [ROW_COUNT-1:0][ACC_WIDTH-1:0] acc;
    } result_t;

    typedef enum logic [2:0] {IDLE, CLEAR, FETCH, DRAIN, OUTPUT, ACK} run_state_t;

endpackage

//--- hdl/accel_top.sv
// ---------------------------------------------------------------------------
// Subsystem top: weight and input memories, route config, run controller,
// operand fetch, PE column and output serializer
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module accel_top import accel_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  mem_write_t           i_mem_wr,
    input  cfg_write_t           i_cfg_wr,
    input  logic                 i_route_req,
    output logic                 o_route_ack,
    output logic [ACC_WIDTH-1:0] o_result,
    output logic                 o_result_valid
);

    logic                  w_we, i_we;
    logic                  busy, clear, start, load;
    logic                  fetch_done, out_done;
    logic [ADDR_WIDTH-1:0] w_raddr, i_raddr;
    weight_word_t          weight;
    ifmap_word_t           ifmap;
    route_cfg_t            cfg;
    operand_t              operand;
    result_t               result;

    // Host write steering
    assign w_we = i_mem_wr.en && (i_mem_wr.sel == SEL_WEIGHT);
    assign i_we = i_mem_wr.en && (i_mem_wr.sel == SEL_INPUT);

    sram_buffer #(.payload_t(weight_word_t)) w_sram_inst (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_we   (w_we),
        .i_waddr(i_mem_wr.addr),
        .i_wdata(weight_word_t'(i_mem_wr.data[DATA_WIDTH-1:0])),
        .i_raddr(w_raddr),
        .o_rdata(weight)
    );

    sram_buffer #(.payload_t(ifmap_word_t)) i_sram_inst (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_we   (i_we),
        .i_waddr(i_mem_wr.addr),
        .i_wdata(ifmap_word_t'(i_mem_wr.data)),
        .i_raddr(i_raddr),
        .o_rdata(ifmap)
    );

    route_config cfg_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cfg_wr(i_cfg_wr), .i_busy(busy), .o_cfg(cfg)
    );

    route_controller ctrl_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_route_req (i_route_req),
        .o_route_ack (o_route_ack),
        .o_busy      (busy),
        .o_clear     (clear),
        .o_start     (start),
        .o_load      (load),
        .i_fetch_done(fetch_done),
        .i_out_done  (out_done)
    );

    operand_fetch fetch_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(start), .i_cfg(cfg),
        .o_w_raddr(w_raddr), .o_i_raddr(i_raddr), .i_weight(weight), .i_ifmap(ifmap),
        .o_operand(operand), .o_fetch_done(fetch_done)
    );

    pe_column pe_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(clear), .i_operand(operand),
        .o_result(result)
    );

    output_router or_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_load(load), .i_result(result),
        .o_result(o_result), .o_result_valid(o_result_valid), .o_out_done(out_done)
    );

endmodule

//--- hdl/operand_fetch.sv
// ---------------------------------------------------------------------------
// Operand fetch: steps both memory read addresses together and pairs the
// returned weight and input words with a delayed valid
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module operand_fetch import accel_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  route_cfg_t            i_cfg,
    output logic [ADDR_WIDTH-1:0] o_w_raddr,
    output logic [ADDR_WIDTH-1:0] o_i_raddr,
    input  weight_word_t          i_weight,
    input  ifmap_word_t           i_ifmap,
    output operand_t              o_operand,
    output logic                  o_fetch_done
);

    logic                  active;
    logic [ADDR_WIDTH-1:0] remaining;
    logic                  empty_done;
    logic                  issue_d;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active     <= 1'b0;
            remaining  <= '0;
            empty_done <= 1'b0;
            issue_d    <= 1'b0;
            o_w_raddr  <= '0;
            o_i_raddr  <= '0;
        end else begin
            // Read data comes back one cycle after its address
            issue_d    <= active;
            empty_done <= i_start && (i_cfg.route_size == '0);
            if (i_start) begin
                active    <= (i_cfg.route_size != '0);
                remaining <= i_cfg.route_size;
                o_w_raddr <= i_cfg.w_start;
                o_i_raddr <= i_cfg.i_start;
            end else if (active) begin
                // Addresses wrap around the 64 entries
                o_w_raddr <= o_w_raddr + 1'b1;
                o_i_raddr <= o_i_raddr + 1'b1;
                remaining <= remaining - 1'b1;
                if (remaining == ADDR_WIDTH'(1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Done with the last address, or right away for an empty route
    assign o_fetch_done = (active && (remaining == ADDR_WIDTH'(1))) || empty_done;

    assign o_operand = '{valid: issue_d, weight: i_weight, ifmap: i_ifmap};

endmodule

//--- hdl/output_router.sv
// ---------------------------------------------------------------------------
// Result serializer: captures the row accumulators and sends them out
// one row per cycle, flagging the last one
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module output_router import accel_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_load,
    input  result_t              i_result,
    output logic [ACC_WIDTH-1:0] o_result,
    output logic                 o_result_valid,
    output logic                 o_out_done
);

    result_t                  shift_q;
    logic [ROW_IDX_WIDTH-1:0] row_q;
    logic                     valid_q;

    // Row 0 always sits at the bottom of the shift register
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            shift_q <= i_result;
        end else if (valid_q) begin
            shift_q.acc <= {{ACC_WIDTH{1'b0}}, shift_q.acc[ROW_COUNT-1:1]};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            row_q   <= '0;
        end else if (i_load) begin
            valid_q <= 1'b1;
            row_q   <= '0;
        end else if (valid_q) begin
            row_q <= row_q + 1'b1;
            if (o_out_done) begin
                valid_q <= 1'b0;
            end
        end
    end

    assign o_result       = shift_q.acc[0];
    assign o_result_valid = valid_q;
    assign o_out_done     = valid_q && (row_q == ROW_IDX_WIDTH'(ROW_COUNT - 1));

endmodule

//--- hdl/pe_column.sv
// ---------------------------------------------------------------------------
// One column of four multiply-accumulate elements, weight broadcast to
// all rows, product stage followed by a wrapping accumulator
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module pe_column import accel_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_clear,
    input  operand_t i_operand,
    output result_t  o_result
);

    logic [ROW_COUNT-1:0][ACC_WIDTH-1:0] product;
    logic                                prod_valid;
    result_t                             acc_q;

    // Product stage, row r takes lane r
    always_ff @(posedge i_clk) begin
        for (int r = 0; r < ROW_COUNT; r++) begin
            product[r] <= ACC_WIDTH'($signed(i_operand.ifmap.lane[r]) * i_operand.weight);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prod_valid <= 1'b0;
        end else if (i_clear) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= i_operand.valid;
        end
    end

    // Accumulate stage, 16 bit wraparound
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else if (i_clear) begin
            acc_q <= '0;
        end else if (prod_valid) begin
            for (int r = 0; r < ROW_COUNT; r++) begin
                acc_q.acc[r] <= acc_q.acc[r] + product[r];
            end
        end
    end

    assign o_result = acc_q;

endmodule

//--- hdl/route_config.sv
// ---------------------------------------------------------------------------
// Route parameter registers written by the host, held steady while a run
// is in progress
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module route_config import accel_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  cfg_write_t i_cfg_wr,
    input  logic       i_busy,
    output route_cfg_t o_cfg
);

    route_cfg_t cfg_q;
    logic       wr_ok;

    // Writes are dropped for the length of a run
    assign wr_ok = i_cfg_wr.en && !i_busy;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cfg_q <= '0;
        end else if (wr_ok) begin
            unique case (i_cfg_wr.field)
                CFG_W_START: begin
                    cfg_q.w_start <= i_cfg_wr.value;
                end
                CFG_I_START: begin
                    cfg_q.i_start <= i_cfg_wr.value;
                end
                CFG_ROUTE_SIZE: begin
                    cfg_q.route_size <= i_cfg_wr.value;
                end
                default: begin
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    assign o_cfg = cfg_q;

endmodule

//--- hdl/route_controller.sv
// ---------------------------------------------------------------------------
// Run sequencer: req/ack handshake with the host, accumulator clear,
// fetch start, pipeline drain and result readout
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module route_controller import accel_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_route_req,
    output logic o_route_ack,
    output logic o_busy,
    output logic o_clear,
    output logic o_start,
    output logic o_load,
    input  logic i_fetch_done,
    input  logic i_out_done
);

    run_state_t state_q;
    run_state_t state_d;
    logic       drain_cnt;
    logic       drain_last;
    logic       load_q;

    assign drain_last = (drain_cnt == 1'(DRAIN_CYCLES - 1));

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (i_route_req) begin
                    state_d = CLEAR;
                end
            end
            CLEAR: begin
                state_d = FETCH;
            end
            FETCH: begin
                if (i_fetch_done) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_last) begin
                    state_d = OUTPUT;
                end
            end
            OUTPUT: begin
                if (i_out_done) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                // Hold until the host drops req
                if (!i_route_req) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= IDLE;
            drain_cnt <= 1'b0;
            load_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            drain_cnt <= (state_q == DRAIN) ? drain_cnt + 1'b1 : 1'b0;
            // Single load pulse on entry to OUTPUT
            load_q    <= (state_q == DRAIN) && drain_last;
        end
    end

    assign o_busy      = (state_q != IDLE);
    assign o_clear     = (state_q == CLEAR);
    assign o_start     = (state_q == CLEAR);
    assign o_load      = load_q;
    assign o_route_ack = (state_q == ACK);

endmodule

//--- hdl/sram_buffer.sv
// ---------------------------------------------------------------------------
// Register array memory, one write port and one registered read port,
// with the stored word type given by a type parameter
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sram_buffer import accel_pkg::*; #(
    parameter type payload_t = logic [DATA_WIDTH-1:0]
)(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_waddr,
    input  payload_t              i_wdata,
    input  logic [ADDR_WIDTH-1:0] i_raddr,
    output payload_t              o_rdata
);

    payload_t mem [MEM_DEPTH];

    // Storage array
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

//--- project.f
hdl/accel_pkg.sv
hdl/sram_buffer.sv
hdl/route_config.sv
hdl/route_controller.sv
hdl/operand_fetch.sv
hdl/pe_column.sv
hdl/output_router.sv
hdl/accel_top.sv
bench/tb_clock_gen.sv
bench/accel_properties.sv
bench/accel_tb.sv
